// File: verilog/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Top address nibble of the SDRAM region.
`define MEM_CACHEABLE_NIBBLE 4'h2

// Default data cache size in lines.
`define MEM_DCACHE_LINES 16

`endif

// File: verilog/pipe_pkg.sv
package pipe_pkg;

	typedef enum logic [1:0] {
		MEMW_1,
		MEMW_2,
		MEMW_4
	} mem_width_t;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_READ,
		MEM_WRITE,
		MEM_FLUSH
	} mem_op_t;

	typedef struct packed {
		logic strobe;
		mem_op_t op;
		mem_width_t width;
		logic mem_signed;
		logic [31:0] mem_address;
		logic [31:0] rd; // Result, or store data.
		logic [4:0] inst_rd;
	} execute_data_t;

	typedef struct packed {
		logic strobe;
		logic [31:0] rd;
		logic [4:0] inst_rd;
	} memory_data_t;

endpackage

// File: verilog/bus_pkg.sv
package bus_pkg;

	typedef struct packed {
		logic request;
		logic rw; // High for write.
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		bus_req_t bus;
		logic flush;
	} cache_req_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_WRITE_WORD,
		S_RMW_READ,
		S_RMW_WRITE,
		S_FLUSH
	} stage_state_t;

	typedef enum logic [2:0] {
		C_IDLE,
		C_BYPASS,
		C_WRITE_BACK,
		C_FILL,
		C_FLUSH_WALK
	} cache_state_t;

endpackage

// File: verilog/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
	input logic i_clock,
	input logic i_reset,

	input pipe_pkg::execute_data_t i_exec,
	output logic o_busy,
	output pipe_pkg::memory_data_t o_mem,

	output bus_pkg::cache_req_t o_cache,
	input bus_pkg::bus_rsp_t i_cache
);

	import pipe_pkg::*;
	import bus_pkg::*;

	stage_state_t state;

	logic last_strobe;
	logic mem_strobe;
	logic [31:0] mem_rd;
	logic [4:0] mem_inst_rd;

	logic req_request;
	logic req_rw;
	logic req_flush;
	logic [31:0] req_address;
	logic [31:0] req_wdata;

	logic new_item;
	logic finish;
	logic [31:0] finish_rd;
	logic [4:0] lane_shift;
	logic [31:0] rdata_lane;
	logic [31:0] load_value;
	logic [31:0] lane_mask;
	logic [31:0] merged_word;

	assign new_item = (i_exec.strobe != last_strobe);
	assign o_busy = new_item && (i_exec.op != MEM_NONE);

	assign lane_shift = {i_exec.mem_address[1:0], 3'b000};
	assign rdata_lane = i_cache.rdata >> lane_shift;

	always_comb begin
		case (i_exec.width)
			MEMW_1: load_value = {{24{i_exec.mem_signed & rdata_lane[7]}}, rdata_lane[7:0]};
			MEMW_2: load_value = {{16{i_exec.mem_signed & rdata_lane[15]}}, rdata_lane[15:0]};
			default: load_value = i_cache.rdata;
		endcase
	end

	// Store lane merged into the word just read.
	always_comb begin
		if (i_exec.width == MEMW_1)
			lane_mask = 32'h0000_00ff << lane_shift;
		else
			lane_mask = 32'h0000_ffff << lane_shift;
		merged_word = (i_cache.rdata & ~lane_mask) | ((i_exec.rd << lane_shift) & lane_mask);
	end

	always_comb begin
		finish = 1'b0;
		finish_rd = i_exec.rd;
		case (state)
			S_IDLE: finish = new_item && (i_exec.op == MEM_NONE);
			S_READ: begin
				finish = i_cache.ready;
				finish_rd = load_value;
			end
			S_WRITE_WORD, S_FLUSH: finish = i_cache.ready;
			S_RMW_WRITE: finish = req_request && i_cache.ready;
			default: finish = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= S_IDLE;
			req_request <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (new_item) begin
						case (i_exec.op)
							MEM_READ: begin
								req_request <= 1'b1;
								state <= S_READ;
							end
							MEM_WRITE: begin
								req_request <= 1'b1;
								state <= (i_exec.width == MEMW_4) ? S_WRITE_WORD : S_RMW_READ;
							end
							MEM_FLUSH: begin
								req_request <= 1'b1;
								state <= S_FLUSH;
							end
							default: state <= S_IDLE;
						endcase
					end
				end
				S_READ, S_WRITE_WORD, S_FLUSH: begin
					if (i_cache.ready) begin
						req_request <= 1'b0;
						state <= S_IDLE;
					end
				end
				S_RMW_READ: begin
					if (i_cache.ready) begin
						req_request <= 1'b0; // Low one cycle between the two accesses.
						state <= S_RMW_WRITE;
					end
				end
				S_RMW_WRITE: begin
					if (!req_request)
						req_request <= 1'b1;
					else if (i_cache.ready) begin
						req_request <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		case (state)
			S_IDLE: begin
				req_address <= {i_exec.mem_address[31:2], 2'b00};
				req_rw <= (i_exec.op == MEM_WRITE) && (i_exec.width == MEMW_4);
				req_flush <= (i_exec.op == MEM_FLUSH);
				req_wdata <= i_exec.rd;
			end
			S_RMW_READ: begin
				if (i_cache.ready) begin
					req_rw <= 1'b1;
					req_wdata <= merged_word;
				end
			end
			default: req_rw <= req_rw;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mem_strobe <= 1'b0;
			last_strobe <= 1'b0;
		end else if (finish) begin
			mem_strobe <= ~mem_strobe;
			last_strobe <= i_exec.strobe;
		end
	end

	always_ff @(posedge i_clock) begin
		if (finish) begin
			mem_rd <= finish_rd;
			mem_inst_rd <= i_exec.inst_rd;
		end
	end

	always_comb begin
		o_mem.strobe = mem_strobe;
		o_mem.rd = mem_rd;
		o_mem.inst_rd = mem_inst_rd;

		o_cache.bus.request = req_request;
		o_cache.bus.rw = req_rw;
		o_cache.bus.address = req_address;
		o_cache.bus.wdata = req_wdata;
		o_cache.flush = req_flush;
	end

endmodule

// File: verilog/dcache.sv
`include "mem_defs.svh"

`timescale 1ns/1ns

module dcache #(
	parameter int LINES = `MEM_DCACHE_LINES
)(
	input logic i_clock,
	input logic i_reset,

	input bus_pkg::cache_req_t i_req,
	output bus_pkg::bus_rsp_t o_rsp,

	output bus_pkg::bus_req_t o_bus,
	input bus_pkg::bus_rsp_t i_bus
);

	import bus_pkg::*;

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = 30 - IDX_W;

	cache_state_t state;

	logic [31:0] data_mem [LINES];
	logic [TAG_W-1:0] tag_mem [LINES];
	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;

	logic [IDX_W-1:0] walk_idx;

	logic bus_request;
	logic bus_rw;
	logic [31:0] bus_address;
	logic [31:0] bus_wdata;

	logic rsp_ready;
	logic [31:0] rsp_rdata;

	logic [IDX_W-1:0] req_idx;
	logic [TAG_W-1:0] req_tag;
	logic cacheable;
	logic hit;
	logic accept;

	assign req_idx = i_req.bus.address[IDX_W+1:2];
	assign req_tag = i_req.bus.address[31:IDX_W+2];
	assign cacheable = (i_req.bus.address[31:28] == `MEM_CACHEABLE_NIBBLE);
	assign hit = valid[req_idx] && (tag_mem[req_idx] == req_tag);

	// Request is still high in the cycle of the ready pulse.
	assign accept = i_req.bus.request && !rsp_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= C_IDLE;
			bus_request <= 1'b0;
			rsp_ready <= 1'b0;
			valid <= '0;
			dirty <= '0;
			walk_idx <= '0;
		end else begin
			rsp_ready <= 1'b0;
			case (state)
				C_IDLE: begin
					if (accept) begin
						if (i_req.flush) begin
							walk_idx <= '0;
							state <= C_FLUSH_WALK;
						end else if (!cacheable) begin
							bus_request <= 1'b1;
							bus_rw <= i_req.bus.rw;
							bus_address <= i_req.bus.address;
							bus_wdata <= i_req.bus.wdata;
							state <= C_BYPASS;
						end else if (hit) begin
							if (i_req.bus.rw) begin
								data_mem[req_idx] <= i_req.bus.wdata;
								dirty[req_idx] <= 1'b1;
							end
							rsp_rdata <= data_mem[req_idx];
							rsp_ready <= 1'b1;
						end else if (valid[req_idx] && dirty[req_idx]) begin
							bus_request <= 1'b1; // Victim goes out first.
							bus_rw <= 1'b1;
							bus_address <= {tag_mem[req_idx], req_idx, 2'b00};
							bus_wdata <= data_mem[req_idx];
							state <= C_WRITE_BACK;
						end else begin
							bus_request <= 1'b1;
							bus_rw <= 1'b0;
							bus_address <= i_req.bus.address;
							state <= C_FILL;
						end
					end
				end
				C_BYPASS: begin
					if (i_bus.ready) begin
						bus_request <= 1'b0;
						rsp_rdata <= i_bus.rdata;
						rsp_ready <= 1'b1;
						state <= C_IDLE;
					end
				end
				C_WRITE_BACK: begin
					if (i_bus.ready) begin
						bus_request <= 1'b0;
						dirty[req_idx] <= 1'b0;
						state <= C_FILL;
					end
				end
				C_FILL: begin
					if (!bus_request) begin
						bus_request <= 1'b1;
						bus_rw <= 1'b0;
						bus_address <= i_req.bus.address;
					end else if (i_bus.ready) begin
						bus_request <= 1'b0;
						tag_mem[req_idx] <= req_tag;
						valid[req_idx] <= 1'b1;
						if (i_req.bus.rw) begin
							data_mem[req_idx] <= i_req.bus.wdata;
							dirty[req_idx] <= 1'b1;
						end else begin
							data_mem[req_idx] <= i_bus.rdata;
							dirty[req_idx] <= 1'b0;
						end
						rsp_rdata <= i_bus.rdata;
						rsp_ready <= 1'b1;
						state <= C_IDLE;
					end
				end
				C_FLUSH_WALK: begin
					if (bus_request) begin
						if (i_bus.ready) begin
							bus_request <= 1'b0;
							dirty[walk_idx] <= 1'b0;
							valid[walk_idx] <= 1'b0;
							if (walk_idx == IDX_W'(LINES - 1)) begin
								rsp_ready <= 1'b1;
								state <= C_IDLE;
							end else
								walk_idx <= walk_idx + 1'b1;
						end
					end else if (valid[walk_idx] && dirty[walk_idx]) begin
						bus_request <= 1'b1;
						bus_rw <= 1'b1;
						bus_address <= {tag_mem[walk_idx], walk_idx, 2'b00};
						bus_wdata <= data_mem[walk_idx];
					end else begin
						valid[walk_idx] <= 1'b0; // A clean line is only invalidated.
						if (walk_idx == IDX_W'(LINES - 1)) begin
							rsp_ready <= 1'b1;
							state <= C_IDLE;
						end else
							walk_idx <= walk_idx + 1'b1;
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	always_comb begin
		o_bus.request = bus_request;
		o_bus.rw = bus_rw;
		o_bus.address = bus_address;
		o_bus.wdata = bus_wdata;

		o_rsp.ready = rsp_ready;
		o_rsp.rdata = rsp_rdata;
	end

endmodule

// File: verilog/mem_subsystem.sv
`include "mem_defs.svh"

`timescale 1ns/1ns

module mem_subsystem (
	input logic i_clock,
	input logic i_reset,

	input pipe_pkg::execute_data_t i_exec,
	output logic o_busy,
	output pipe_pkg::memory_data_t o_mem,

	output bus_pkg::bus_req_t o_bus,
	input bus_pkg::bus_rsp_t i_bus
);

	import bus_pkg::*;

	cache_req_t cache_req;
	bus_rsp_t cache_rsp;

	mem_stage mem_stage_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_exec(i_exec),
		.o_busy(o_busy),
		.o_mem(o_mem),
		.o_cache(cache_req),
		.i_cache(cache_rsp)
	);

	dcache #(
		.LINES(`MEM_DCACHE_LINES)
	) dcache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(cache_req),
		.o_rsp(cache_rsp),
		.o_bus(o_bus),
		.i_bus(i_bus)
	);

endmodule

// File: bench/bus_memory_model.sv
`timescale 1ns/1ns

module bus_memory_model (
	input logic i_clock,
	input logic i_reset,
	input bus_pkg::bus_req_t i_bus,
	output bus_pkg::bus_rsp_t o_bus
);

	logic [31:0] words [128];
	logic waiting;
	logic [1:0] delay;
	logic [6:0] index;

	assign index = {i_bus.address[28], i_bus.address[7:2]}; // Region bit and word offset.

	initial begin
		int i;
		logic [31:0] address;
		for (i = 0; i < 128; i++) begin
			address = {i[6] ? 4'h1 : 4'h2, 20'h0, i[5:0], 2'b00};
			words[i] = (address * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
		end
	end

	// Ready follows a random wait of 0 to 3 extra cycles.
	always @(posedge i_clock) begin
		if (i_reset) begin
			waiting <= 1'b0;
			o_bus.ready <= 1'b0;
		end else begin
			o_bus.ready <= 1'b0;
			if (i_bus.request && !o_bus.ready) begin
				if (!waiting) begin
					waiting <= 1'b1;
					delay <= 2'($urandom_range(3, 0));
				end else if (delay != 2'd0)
					delay <= delay - 2'd1;
				else begin
					waiting <= 1'b0;
					o_bus.ready <= 1'b1;
					if (i_bus.rw)
						words[index] <= i_bus.wdata;
					else
						o_bus.rdata <= words[index];
				end
			end
		end
	end

endmodule

// File: bench/tb_mem_subsystem.sv
`timescale 1ns/1ns

`include "mem_defs.svh"

module tb_mem_subsystem;

	import pipe_pkg::*;
	import bus_pkg::*;

	localparam int CYCLE_LIMIT = 20000; // About 300 items at worst miss or flush latency.

	logic clock = 1'b0;
	logic reset;
	execute_data_t exec;
	logic busy;
	memory_data_t mem;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	logic [31:0] shadow [128];
	logic [31:0] last_write_address;
	logic [31:0] last_write_data;
	int cycles = 0;
	int errors = 0;
	int tests = 0;
	int items = 0;
	int toggles = 0;

	always #5 clock = ~clock;

	mem_subsystem mem_subsystem_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_exec(exec),
		.o_busy(busy),
		.o_mem(mem),
		.o_bus(bus_req),
		.i_bus(bus_rsp)
	);

	bus_memory_model memory_model_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_bus(bus_req),
		.o_bus(bus_rsp)
	);

	always @(posedge clock) begin
		cycles++;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	always @(mem.strobe) toggles++;

	always @(posedge clock) begin
		if (bus_req.request && bus_req.rw) begin
			last_write_address <= bus_req.address;
			last_write_data <= bus_req.wdata;
		end
	end

	function automatic int word_index(input logic [31:0] address);
		return int'({address[28], address[7:2]});
	endfunction

	function automatic logic [31:0] make_address(input logic [3:0] nibble, input int word,
			input logic [1:0] lane);
		return {nibble, 20'h0, word[5:0], lane};
	endfunction

	function automatic logic [31:0] expected_load(input logic [31:0] address,
			input mem_width_t width, input logic is_signed);
		logic [31:0] lane;
		lane = shadow[word_index(address)] >> (8 * int'(address[1:0]));
		case (width)
			MEMW_1: return is_signed ? 32'($signed(lane[7:0])) : 32'(lane[7:0]);
			MEMW_2: return is_signed ? 32'($signed(lane[15:0])) : 32'(lane[15:0]);
			default: return lane;
		endcase
	endfunction

	task automatic store_shadow(input logic [31:0] address, input mem_width_t width,
			input logic [31:0] data);
		int idx;
		int lanes;
		int k;
		idx = word_index(address);
		lanes = (width == MEMW_1) ? 1 : (width == MEMW_2) ? 2 : 4;
		for (k = 0; k < lanes; k++)
			shadow[idx][8 * (int'(address[1:0]) + k) +: 8] = data[8 * k +: 8];
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic compare_memory(input int first, input int last);
		int i;
		for (i = first; i <= last; i++)
			check_value($sformatf("memory word %0d", i), memory_model_i.words[i], shadow[i]);
	endtask

	// Sends one item by a strobe toggle and waits for the answering toggle of o_mem.strobe.
	task automatic send_item(input mem_op_t op, input mem_width_t width, input logic is_signed,
			input logic [31:0] address, input logic [31:0] data, output logic [31:0] result);
		logic old_strobe;
		logic [4:0] target;
		int wait_cycles;
		old_strobe = mem.strobe;
		target = 5'($urandom);
		wait_cycles = 0;
		exec.op = op;
		exec.width = width;
		exec.mem_signed = is_signed;
		exec.mem_address = address;
		exec.rd = data;
		exec.inst_rd = target;
		exec.strobe = ~exec.strobe;
		items++;
		#1;
		check_value("o_busy", 32'(busy), 32'(op != MEM_NONE));
		while (mem.strobe == old_strobe) begin
			@(negedge clock);
			wait_cycles++;
			if (mem.strobe == old_strobe)
				check_value("o_busy", 32'(busy), 32'd1);
		end
		if (op == MEM_NONE)
			check_value("pass-through latency", 32'(wait_cycles), 32'd1);
		check_value("o_mem.inst_rd", 32'(mem.inst_rd), 32'(target));
		check_value("o_mem.strobe toggle count", 32'(toggles), 32'(items));
		result = mem.rd;
	endtask

	task automatic end_test(input string name, input int first_error);
		tests++;
		$display("Test %s finished with %0d errors", name, errors - first_error);
	endtask

	initial begin
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] result;
		logic [3:0] nibble;
		logic [1:0] lane;
		mem_width_t width;
		logic is_signed;
		int first_error;
		int n;
		void'($urandom(19));
		exec = '0;
		reset = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		toggles = 0;
		for (n = 0; n < 128; n++)
			shadow[n] = memory_model_i.words[n];

		first_error = errors;
		for (n = 0; n < 10; n++) begin
			data = $urandom;
			send_item(MEM_NONE, MEMW_4, 1'b0, 32'h0, data, result);
			check_value("o_mem.rd", result, data);
		end
		end_test("pass-through", first_error);

		first_error = errors;
		for (n = 0; n < 80; n++) begin
			nibble = (n < 40) ? `MEM_CACHEABLE_NIBBLE : 4'h1;
			address = make_address(nibble, int'($urandom_range(63, 0)), 2'b00);
			if ($urandom_range(1, 0) == 1) begin
				data = $urandom;
				send_item(MEM_WRITE, MEMW_4, 1'b0, address, data, result);
				store_shadow(address, MEMW_4, data);
				if (nibble != `MEM_CACHEABLE_NIBBLE) begin
					check_value("o_bus.address", last_write_address, address);
					check_value("o_bus.wdata", last_write_data, data);
				end
			end else begin
				send_item(MEM_READ, MEMW_4, 1'b0, address, 32'h0, result);
				check_value("o_mem.rd", result, expected_load(address, MEMW_4, 1'b0));
			end
		end
		compare_memory(64, 127); // Uncached half is already up to date.
		end_test("word access", first_error);

		first_error = errors;
		for (n = 0; n < 32; n++) begin
			nibble = n[4] ? 4'h1 : `MEM_CACHEABLE_NIBBLE;
			width = n[2] ? MEMW_2 : MEMW_1;
			lane = {n[1], n[0] & ~n[2]};
			is_signed = n[3];
			address = make_address(nibble, int'($urandom_range(63, 0)), lane);
			send_item(MEM_READ, width, is_signed, address, 32'h0, result);
			check_value("o_mem.rd", result, expected_load(address, width, is_signed));
		end
		end_test("sub-word load", first_error);

		first_error = errors;
		for (n = 0; n < 32; n++) begin
			nibble = n[4] ? 4'h1 : `MEM_CACHEABLE_NIBBLE;
			width = n[2] ? MEMW_2 : MEMW_1;
			lane = {n[1], n[0] & ~n[2]};
			address = make_address(nibble, int'($urandom_range(63, 0)), lane);
			data = $urandom;
			send_item(MEM_WRITE, width, 1'b0, address, data, result);
			store_shadow(address, width, data);
			address[1:0] = 2'b00;
			send_item(MEM_READ, MEMW_4, 1'b0, address, 32'h0, result);
			check_value("o_mem.rd", result, expected_load(address, MEMW_4, 1'b0));
		end
		end_test("sub-word store", first_error);

		first_error = errors;
		for (n = 0; n < 24; n++) begin
			address = make_address(`MEM_CACHEABLE_NIBBLE,
				int'($urandom_range(3, 0)) * `MEM_DCACHE_LINES +
				int'($urandom_range(`MEM_DCACHE_LINES - 1, 0)), 2'b00);
			data = $urandom;
			send_item(MEM_WRITE, MEMW_4, 1'b0, address, data, result);
			store_shadow(address, MEMW_4, data);
		end
		data = $urandom;
		send_item(MEM_FLUSH, MEMW_4, 1'b0, 32'h0, data, result);
		check_value("o_mem.rd", result, data);
		compare_memory(0, 127);
		end_test("flush", first_error);

		$display("Summary: %0d tests, %0d items, %0d errors", tests, items, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sources.f
+incdir+verilog
verilog/pipe_pkg.sv
verilog/bus_pkg.sv
verilog/mem_stage.sv
verilog/dcache.sv
verilog/mem_subsystem.sv
bench/bus_memory_model.sv
bench/tb_mem_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS := --binary --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP := tb_mem_subsystem
RTL_TOP := mem_subsystem
FILELIST := sources.f
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
